/* all.f */
+incdir+test
hw/rv_pkg.sv
hw/op_decode.sv
hw/imm_extract.sv
hw/rv_decoder.sv
test/tb_rv_decoder.sv

/* Makefile */
SHELL     := /bin/bash
VERILATOR := verilator
VFLAGS    := --timing --assert --timescale 1ns/1ps
TOP       := tb_rv_decoder
FILELIST  := all.f
LOG       := sim.log
FAIL_MSG  := Simulation failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	set -o pipefail; ./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "result: FAIL"; \
		exit 1; \
	else \
		echo "result: PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* test/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
    logic [63:0]                   name;
    logic [31:0]                   word;
    rv_pkg::op_e                   op;
    logic [rv_pkg::reg_idx_w-1:0]  rs1;
    logic [rv_pkg::reg_idx_w-1:0]  rs2;
    logic [rv_pkg::reg_idx_w-1:0]  rd;
    logic [31:0]                   imm;
    logic                          has_imm;
} vector_t;

localparam int num_rows = 28;

// each row holds name, instruction word, op, rs1, rs2, rd, imm and has_imm
localparam vector_t vectors [num_rows] = '{
    '{"add",      32'h002081b3, rv_pkg::op_add,     5'd1,  5'd2,  5'd3,  32'h00000000, 1'b0},
    '{"sub",      32'h407302b3, rv_pkg::op_sub,     5'd6,  5'd7,  5'd5,  32'h00000000, 1'b0},
    '{"srl",      32'h00c5d533, rv_pkg::op_srl,     5'd11, 5'd12, 5'd10, 32'h00000000, 1'b0},
    '{"sra",      32'h40c5d533, rv_pkg::op_sra,     5'd11, 5'd12, 5'd10, 32'h00000000, 1'b0},
    '{"sltu",     32'h01df3fb3, rv_pkg::op_sltu,    5'd30, 5'd29, 5'd31, 32'h00000000, 1'b0},
    '{"addi_pos", 32'h06410093, rv_pkg::op_add,     5'd2,  5'd0,  5'd1,  32'h00000064, 1'b1},
    '{"addi_neg", 32'hfff28213, rv_pkg::op_add,     5'd5,  5'd0,  5'd4,  32'hffffffff, 1'b1},
    '{"xori_min", 32'h8003c313, rv_pkg::op_xor,     5'd7,  5'd0,  5'd6,  32'hfffff800, 1'b1},
    '{"slli",     32'h01f49413, rv_pkg::op_sll,     5'd9,  5'd0,  5'd8,  32'h0000001f, 1'b1},
    '{"srli",     32'h0034d413, rv_pkg::op_srl,     5'd9,  5'd0,  5'd8,  32'h00000003, 1'b1},
    '{"srai",     32'h4034d413, rv_pkg::op_sra,     5'd9,  5'd0,  5'd8,  32'h00000003, 1'b1},
    '{"lw",       32'hffc12703, rv_pkg::op_lw,      5'd2,  5'd0,  5'd14, 32'hfffffffc, 1'b1},
    '{"lbu",      32'h0071c083, rv_pkg::op_lbu,     5'd3,  5'd0,  5'd1,  32'h00000007, 1'b1},
    '{"jalr",     32'h010280e7, rv_pkg::op_jalr,    5'd5,  5'd0,  5'd1,  32'h00000010, 1'b1},
    '{"sw",       32'h00712423, rv_pkg::op_sw,      5'd2,  5'd7,  5'd0,  32'h00000008, 1'b1},
    '{"sb",       32'hfe530fa3, rv_pkg::op_sb,      5'd6,  5'd5,  5'd0,  32'hffffffff, 1'b1},
    '{"beq",      32'h00208463, rv_pkg::op_beq,     5'd1,  5'd2,  5'd0,  32'h00000008, 1'b1},
    '{"bne",      32'hfe4198e3, rv_pkg::op_bne,     5'd3,  5'd4,  5'd0,  32'hfffffff0, 1'b1},
    '{"blt",      32'h7eb54fe3, rv_pkg::op_blt,     5'd10, 5'd11, 5'd0,  32'h00000ffe, 1'b1},
    '{"lui",      32'h123452b7, rv_pkg::op_lui,     5'd0,  5'd0,  5'd5,  32'h12345000, 1'b1},
    '{"auipc",    32'hfffff317, rv_pkg::op_auipc,   5'd0,  5'd0,  5'd6,  32'hfffff000, 1'b1},
    '{"jal_pos",  32'h001000ef, rv_pkg::op_jal,     5'd0,  5'd0,  5'd1,  32'h00000800, 1'b1},
    '{"jal_neg",  32'hffdff06f, rv_pkg::op_jal,     5'd0,  5'd0,  5'd0,  32'hfffffffc, 1'b1},
    '{"zero_wd",  32'h00000000, rv_pkg::op_illegal, 5'd0,  5'd0,  5'd0,  32'h00000000, 1'b0},
    '{"rvc_word", 32'h00004501, rv_pkg::op_illegal, 5'd0,  5'd0,  5'd0,  32'h00000000, 1'b0},
    '{"bad_opc",  32'h002081ff, rv_pkg::op_illegal, 5'd0,  5'd0,  5'd0,  32'h00000000, 1'b0},
    '{"bad_bf3",  32'h0020a463, rv_pkg::op_illegal, 5'd0,  5'd0,  5'd0,  32'h00000000, 1'b0},
    '{"bad_lf3",  32'hffc13703, rv_pkg::op_illegal, 5'd0,  5'd0,  5'd0,  32'h00000000, 1'b0}
};

`endif

/* test/tb_rv_decoder.sv */
module tb_rv_decoder;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int xlen = 32;
    localparam int clk_period = 20;

    `include "decode_vectors.svh"

    // each row may take up to four cycles over both passes
    localparam int watchdog_ns = num_rows * 4 * clk_period + 200;

    logic                          clk;
    logic                          rst;
    logic                          in_valid;
    logic [31:0]                   instr;
    logic                          out_valid;
    rv_pkg::op_e                   op;
    logic [rv_pkg::reg_idx_w-1:0]  rs1;
    logic [rv_pkg::reg_idx_w-1:0]  rs2;
    logic [rv_pkg::reg_idx_w-1:0]  rd;
    logic [xlen-1:0]               imm;
    logic                          has_imm;

    int   value_errors;
    int   valid_errors;
    logic pending_valid;
    int   pending_row;
    logic row_sent;
    int   last_row;

    rv_decoder #(
        .xlen (xlen)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .instr     (instr),
        .out_valid (out_valid),
        .op        (op),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .has_imm   (has_imm)
    );

    always #(clk_period / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic string name_text(input logic [63:0] packed_name);
        string text;
        text = "";
        for (int k = 7; k >= 0; k--) begin
            if (packed_name[k*8 +: 8] != 8'd0) begin
                text = $sformatf("%s%c", text, packed_name[k*8 +: 8]);
            end
        end
        return text;
    endfunction

    task automatic compare_value(input string label, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", label, field, expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_row(input string label, input vector_t row);
        compare_value(label, "op", 32'(row.op), 32'(op));
        compare_value(label, "rs1", 32'(row.rs1), 32'(rs1));
        compare_value(label, "rs2", 32'(row.rs2), 32'(rs2));
        compare_value(label, "rd", 32'(row.rd), 32'(rd));
        compare_value(label, "imm", row.imm, imm);
        compare_value(label, "has_imm", 32'(row.has_imm), 32'(has_imm));
    endtask

    task automatic verify_outputs;
        vector_t row;
        string   label;
        if (pending_valid) begin
            row   = vectors[pending_row];
            label = name_text(row.name);
            if (out_valid !== 1'b1) begin
                $display("out_valid missing for row %s one cycle after it was sent", label);
                valid_errors++;
            end
            compare_row(label, row);
        end else begin
            if (out_valid !== 1'b0) begin
                $display("out_valid is high although no word was sent in the previous cycle");
                valid_errors++;
            end
            // while idle the data outputs keep the last decoded row
            if (row_sent) begin
                row   = vectors[last_row];
                label = {name_text(row.name), "_hold"};
                compare_row(label, row);
            end
        end
    endtask

    task automatic inspect_reset;
        if (out_valid !== 1'b0) begin
            $display("out_valid is not low right after reset");
            valid_errors++;
        end
        compare_value("reset", "op", 32'(rv_pkg::op_illegal), 32'(op));
        compare_value("reset", "rs1", 32'd0, 32'(rs1));
        compare_value("reset", "rs2", 32'd0, 32'(rs2));
        compare_value("reset", "rd", 32'd0, 32'(rd));
        compare_value("reset", "imm", 32'd0, imm);
        compare_value("reset", "has_imm", 32'd0, 32'(has_imm));
    endtask

    // outputs of the last cycle are checked before the next word goes in
    task automatic drive_cycle(input logic valid, input logic [31:0] word, input int row_idx);
        @(posedge clk);
        #2;
        verify_outputs();
        in_valid      = valid;
        instr         = word;
        pending_valid = valid;
        pending_row   = row_idx;
        if (valid) begin
            row_sent = 1'b1;
            last_row = row_idx;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        int idle;
        clk           = 1'b0;
        rst           = 1'b0;
        in_valid      = 1'b0;
        instr         = 32'd0;
        value_errors  = 0;
        valid_errors  = 0;
        pending_valid = 1'b0;
        pending_row   = 0;
        row_sent      = 1'b0;
        last_row      = 0;
        void'($urandom(2772));

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;
        inspect_reset();

        // first pass with random gaps between the rows
        for (int i = 0; i < num_rows; i++) begin
            idle = $urandom_range(2, 0);
            repeat (idle) drive_cycle(1'b0, 32'd0, 0);
            drive_cycle(1'b1, vectors[i].word, i);
        end

        // second pass back to back
        for (int i = 0; i < num_rows; i++) begin
            drive_cycle(1'b1, vectors[i].word, i);
        end
        drive_cycle(1'b0, 32'd0, 0);

        $display("errors: %0d wrong values, %0d valid strobe faults", value_errors, valid_errors);
        if (value_errors + valid_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the decoder test did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* hw/rv_decoder.sv */
module rv_decoder #(
    parameter int xlen = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  logic [31:0]                    instr,
    output logic                           out_valid,
    output rv_pkg::op_e                    op,
    output logic [rv_pkg::reg_idx_w-1:0]   rs1,
    output logic [rv_pkg::reg_idx_w-1:0]   rs2,
    output logic [rv_pkg::reg_idx_w-1:0]   rd,
    output logic [xlen-1:0]                imm,
    output logic                           has_imm
);

    rv_pkg::op_e                   op_next;
    rv_pkg::fmt_e                  fmt;
    logic                          use_rs1;
    logic                          use_rs2;
    logic                          use_rd;
    logic [xlen-1:0]               imm_next;
    logic [rv_pkg::reg_idx_w-1:0]  rs1_next;
    logic [rv_pkg::reg_idx_w-1:0]  rs2_next;
    logic [rv_pkg::reg_idx_w-1:0]  rd_next;
    logic                          has_imm_next;

    op_decode u_op_decode (
        .instr   (instr),
        .op      (op_next),
        .fmt     (fmt),
        .use_rs1 (use_rs1),
        .use_rs2 (use_rs2),
        .use_rd  (use_rd)
    );

    imm_extract #(
        .xlen (xlen)
    ) u_imm_extract (
        .instr (instr),
        .fmt   (fmt),
        .imm   (imm_next)
    );

    // register fields an instruction does not use are reported as x0
    assign rs1_next     = use_rs1 ? instr[19:15] : '0;
    assign rs2_next     = use_rs2 ? instr[24:20] : '0;
    assign rd_next      = use_rd  ? instr[11:7]  : '0;
    assign has_imm_next = (fmt != rv_pkg::fmt_none);

    // ~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
            op        <= rv_pkg::op_illegal;
            rs1       <= '0;
            rs2       <= '0;
            rd        <= '0;
            imm       <= '0;
            has_imm   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // data holds its last value while no word arrives
            if (in_valid) begin
                op      <= op_next;
                rs1     <= rs1_next;
                rs2     <= rs2_next;
                rd      <= rd_next;
                imm     <= imm_next;
                has_imm <= has_imm_next;
            end
        end
    end

    // one-cycle latency from in_valid to out_valid
    property p_valid_delay;
        @(posedge clk) disable iff (!rst)
            $past(rst) |-> (out_valid == $past(in_valid));
    endproperty

    assert property (p_valid_delay)
        else $error("rv_decoder: out_valid does not follow in_valid by one cycle");

endmodule

/* hw/imm_extract.sv */
module imm_extract #(
    parameter int xlen = 32
) (
    input  logic [31:0]      instr,
    input  rv_pkg::fmt_e     fmt,
    output logic [xlen-1:0]  imm
);

    logic        sign;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_shamt;
    logic [31:0] raw;

    assign sign = instr[31];

    // ~~~~~~~~~~~~~~~~~~~~
    // immediate layouts
    // ~~~~~~~~~~~~~~~~~~~~
    assign imm_i = {{20{sign}}, instr[31:20]};
    assign imm_s = {{20{sign}}, instr[31:25], instr[11:7]};

    // branch and jump offsets are in halfwords, so bit 0 is always zero
    assign imm_b = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign imm_u     = {instr[31:12], 12'd0};
    assign imm_shamt = {27'd0, instr[24:20]};

    always_comb begin
        case (fmt)
            rv_pkg::fmt_i:     raw = imm_i;
            rv_pkg::fmt_shamt: raw = imm_shamt;
            rv_pkg::fmt_s:     raw = imm_s;
            rv_pkg::fmt_b:     raw = imm_b;
            rv_pkg::fmt_u:     raw = imm_u;
            rv_pkg::fmt_j:     raw = imm_j;
            default:           raw = 32'd0;
        endcase
    end

    // bit 31 of every layout already holds its sign bit
    assign imm = {{(xlen - 31){raw[31]}}, raw[30:0]};

    always_comb begin
        if (fmt == rv_pkg::fmt_b || fmt == rv_pkg::fmt_j) begin
            assert (imm[0] == 1'b0)
                else $error("imm_extract: odd branch or jump offset %0h", imm);
        end
    end

endmodule

/* hw/op_decode.sv */
module op_decode (
    input  logic [31:0]   instr,
    output rv_pkg::op_e   op,
    output rv_pkg::fmt_e  fmt,
    output logic          use_rs1,
    output logic          use_rs2,
    output logic          use_rd
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic            alt;
    logic            word_ok;
    logic            f3_ok;

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // the zero word and all compressed encodings are rejected up front
    assign word_ok = (instr != 32'd0) && (instr[1:0] == 2'b11);

    // funct3 values that are reserved in the branch, load and store groups
    always_comb begin
        case (opcode)
            rv_pkg::opc_branch: f3_ok = (funct3[2:1] != 2'b01);
            rv_pkg::opc_load:   f3_ok = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            rv_pkg::opc_store:  f3_ok = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
            default:            f3_ok = 1'b1;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // operation tables
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        op      = rv_pkg::op_illegal;
        fmt     = rv_pkg::fmt_none;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        if (word_ok) begin
            case (opcode)
                rv_pkg::opc_lui: begin
                    op     = rv_pkg::op_lui;
                    fmt    = rv_pkg::fmt_u;
                    use_rd = 1'b1;
                end
                rv_pkg::opc_auipc: begin
                    op     = rv_pkg::op_auipc;
                    fmt    = rv_pkg::fmt_u;
                    use_rd = 1'b1;
                end
                rv_pkg::opc_jal: begin
                    op     = rv_pkg::op_jal;
                    fmt    = rv_pkg::fmt_j;
                    use_rd = 1'b1;
                end
                rv_pkg::opc_jalr: begin
                    op      = rv_pkg::op_jalr;
                    fmt     = rv_pkg::fmt_i;
                    use_rs1 = 1'b1;
                    use_rd  = 1'b1;
                end
                rv_pkg::opc_branch: begin
                    case (funct3)
                        3'b000:  op = rv_pkg::op_beq;
                        3'b001:  op = rv_pkg::op_bne;
                        3'b100:  op = rv_pkg::op_blt;
                        3'b101:  op = rv_pkg::op_bge;
                        3'b110:  op = rv_pkg::op_bltu;
                        3'b111:  op = rv_pkg::op_bgeu;
                        default: op = rv_pkg::op_illegal;
                    endcase
                    if (f3_ok) begin
                        fmt     = rv_pkg::fmt_b;
                        use_rs1 = 1'b1;
                        use_rs2 = 1'b1;
                    end
                end
                rv_pkg::opc_load: begin
                    case (funct3)
                        3'b000:  op = rv_pkg::op_lb;
                        3'b001:  op = rv_pkg::op_lh;
                        3'b010:  op = rv_pkg::op_lw;
                        3'b100:  op = rv_pkg::op_lbu;
                        3'b101:  op = rv_pkg::op_lhu;
                        default: op = rv_pkg::op_illegal;
                    endcase
                    if (f3_ok) begin
                        fmt     = rv_pkg::fmt_i;
                        use_rs1 = 1'b1;
                        use_rd  = 1'b1;
                    end
                end
                rv_pkg::opc_store: begin
                    case (funct3)
                        3'b000:  op = rv_pkg::op_sb;
                        3'b001:  op = rv_pkg::op_sh;
                        3'b010:  op = rv_pkg::op_sw;
                        default: op = rv_pkg::op_illegal;
                    endcase
                    if (f3_ok) begin
                        fmt     = rv_pkg::fmt_s;
                        use_rs1 = 1'b1;
                        use_rs2 = 1'b1;
                    end
                end
                rv_pkg::opc_op_imm: begin
                    case (funct3)
                        3'b000: op = rv_pkg::op_add;
                        3'b001: op = rv_pkg::op_sll;
                        3'b010: op = rv_pkg::op_slt;
                        3'b011: op = rv_pkg::op_sltu;
                        3'b100: op = rv_pkg::op_xor;
                        3'b101: begin
                            if (alt) begin
                                op = rv_pkg::op_sra;
                            end else begin
                                op = rv_pkg::op_srl;
                            end
                        end
                        3'b110: op = rv_pkg::op_or;
                        3'b111: op = rv_pkg::op_and;
                    endcase
                    // slli, srli and srai carry a shift amount and not an I immediate
                    if (funct3[1:0] == 2'b01) begin
                        fmt = rv_pkg::fmt_shamt;
                    end else begin
                        fmt = rv_pkg::fmt_i;
                    end
                    use_rs1 = 1'b1;
                    use_rd  = 1'b1;
                end
                rv_pkg::opc_op_reg: begin
                    case (funct3)
                        3'b000: begin
                            if (alt) begin
                                op = rv_pkg::op_sub;
                            end else begin
                                op = rv_pkg::op_add;
                            end
                        end
                        3'b001: op = rv_pkg::op_sll;
                        3'b010: op = rv_pkg::op_slt;
                        3'b011: op = rv_pkg::op_sltu;
                        3'b100: op = rv_pkg::op_xor;
                        3'b101: begin
                            if (alt) begin
                                op = rv_pkg::op_sra;
                            end else begin
                                op = rv_pkg::op_srl;
                            end
                        end
                        3'b110: op = rv_pkg::op_or;
                        3'b111: op = rv_pkg::op_and;
                    endcase
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    use_rd  = 1'b1;
                end
                default: begin
                    op = rv_pkg::op_illegal;
                end
            endcase
        end
    end

    // the reserved-funct3 table and the operation tables must agree
    always_comb begin
        if (op == rv_pkg::op_illegal) begin
            assert (fmt == rv_pkg::fmt_none)
                else $error("op_decode: illegal op with immediate format %0d", fmt);
        end
    end

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

    // width of a register index field
    localparam int reg_idx_w = 5;

    // ~~~~~~~~~~~~~~~~~~~~
    // decoded operations
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [4:0] {
        op_add     = 5'b00000,
        op_and     = 5'b00001,
        op_or      = 5'b00010,
        op_sll     = 5'b00011,
        op_srl     = 5'b00100,
        op_slt     = 5'b00101,
        op_sltu    = 5'b00110,
        op_sra     = 5'b00111,
        op_sub     = 5'b01000,
        op_xor     = 5'b01001,
        op_beq     = 5'b01010,
        op_bge     = 5'b01011,
        op_bne     = 5'b01100,
        op_bgeu    = 5'b01101,
        op_lui     = 5'b01110,
        op_auipc   = 5'b01111,
        op_jal     = 5'b10000,
        op_jalr    = 5'b10001,
        op_lb      = 5'b10010,
        op_lh      = 5'b10011,
        op_lw      = 5'b10100,
        op_lbu     = 5'b10101,
        op_lhu     = 5'b10110,
        op_sb      = 5'b10111,
        op_sh      = 5'b11000,
        op_sw      = 5'b11001,
        op_blt     = 5'b11010,
        op_bltu    = 5'b11011,
        op_illegal = 5'b11111
    } op_e;

    // major opcodes, bits 6:0 of a 32-bit instruction
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op_reg = 7'b0110011
    } opcode_e;

    // immediate layouts
    typedef enum logic [2:0] {
        fmt_none  = 3'd0,
        fmt_i     = 3'd1,
        fmt_shamt = 3'd2,
        fmt_s     = 3'd3,
        fmt_b     = 3'd4,
        fmt_u     = 3'd5,
        fmt_j     = 3'd6
    } fmt_e;

endpackage
